// File: vectorPkg.sv
`default_nettype none

package vectorPkg;

	localparam int componentWidth = 32; // Signed Q16.16 component
	localparam int fracBits = 16;
	localparam int componentCount = 3; // x, y and z
	localparam int regCount = 32;
	localparam int regAddrWidth = $clog2(regCount);

	typedef logic [regAddrWidth-1:0] regAddrT; // Register index

	typedef logic signed [componentWidth-1:0] componentT;

	// x sits in the top bits so that lane 2 is x
	typedef struct packed {
		componentT x;
		componentT y;
		componentT z;
	} vectorT; // 96 bits

	typedef logic [componentCount-1:0] maskT; // Bit 2 is x, bit 0 is z

	// Lane view of a vector where the lane index equals the mask bit
	typedef logic [componentCount-1:0][componentWidth-1:0] lanesT;

endpackage

`default_nettype wire

// File: isaPkg.sv
`default_nettype none

package isaPkg;
	import vectorPkg::*;

	localparam int opcodeWidth = 3;

	// Codes 5 to 7 are unused and retire silently
	typedef enum logic [opcodeWidth-1:0] {
		Mov = 3'd0,
		Add = 3'd1,
		Sub = 3'd2,
		Mul = 3'd3,
		Dot = 3'd4
	} opcodeT;

	// Instruction word seen at the core input
	typedef struct packed {
		opcodeT opcode;
		regAddrT dest;
		regAddrT srcA;
		regAddrT srcB;
		maskT mask;
	} instructionT; // 21 bits

	// Decoded instruction with its operands from fetch to execute
	typedef struct packed {
		opcodeT opcode;
		regAddrT dest;
		maskT mask;
		vectorT operandA;
		vectorT operandB;
	} issueT; // 203 bits

	// One register write from the host preload or the writeback
	typedef struct packed {
		regAddrT dest;
		maskT mask;
		vectorT value;
	} regWriteT; // 104 bits

endpackage

`default_nettype wire

// File: operandFetch.sv
`timescale 1ns/1ps
`default_nettype none

module operandFetch
	import vectorPkg::*;
	import isaPkg::*;
(
	input logic Clock,
	input logic Reset,
	input logic instValid, // One strobe per cycle at most
	input instructionT instruction,
	input vectorT readDataA, // Valid one cycle after the address
	input vectorT readDataB,
	input logic writebackValid,
	input regWriteT writeback,
	output regAddrT readAddrA,
	output regAddrT readAddrB,
	output logic issueValid,
	output issueT issue
);

	instructionT heldInst; // Instruction in the issue cycle

	// Merge the lanes that the in-flight writeback is committing right now
	function automatic vectorT bypass(
		input vectorT readData,
		input regAddrT src,
		input logic wbValid,
		input regWriteT wb
	);
		lanesT merged;
		lanesT fresh;
		merged = readData;
		fresh = wb.value;
		for (int c = 0; c < componentCount; c++)
		begin
			if (wbValid && (wb.dest == src) && wb.mask[c])
				merged[c] = fresh[c]; // Newer than the RAM copy
		end
		return merged;
	endfunction

	// Source addresses go straight to the RAM in the strobe cycle
	assign readAddrA = instruction.srcA;
	assign readAddrB = instruction.srcB;

	always_ff @(posedge Clock or posedge Reset)
	begin
		if (Reset)
			issueValid <= 1'b0;
		else
			issueValid <= instValid;
	end

	// Capture the instruction for the issue stage
	always_ff @(posedge Clock)
	begin
		if (instValid)
			heldInst <= instruction;
	end

	/*
	 * The write-first RAM covers the writeback two instructions back.
	 * The one directly before this one is still in the writeback register,
	 * so it is taken from there per lane
	 */
	always_comb
	begin
		issue.opcode = heldInst.opcode;
		issue.dest = heldInst.dest;
		issue.mask = heldInst.mask;
		issue.operandA = bypass(readDataA, heldInst.srcA, writebackValid, writeback);
		issue.operandB = bypass(readDataB, heldInst.srcB, writebackValid, writeback);
	end

endmodule

`default_nettype wire

// File: vectorRegFile.sv
`timescale 1ns/1ps
`default_nettype none

module vectorRegFile
	import vectorPkg::*;
	import isaPkg::*;
(
	input logic Clock,
	input logic Reset,
	input regAddrT readAddrA,
	input regAddrT readAddrB,
	input logic hostWriteValid,
	input regWriteT hostWrite,
	input logic writebackValid,
	input regWriteT writeback,
	output vectorT readDataA, // Registered read data
	output vectorT readDataB
);

	componentT laneMem [componentCount][regCount]; // One array per mask bit
	logic writeValid;
	regWriteT writeSel;
	lanesT writeLanes;
	lanesT readLanesA;
	lanesT readLanesB;

	// True when this lane of addr is being written at the coming edge
	function automatic logic writeHit(input int lane, input regAddrT addr);
		return writeValid && writeSel.mask[lane] && (writeSel.dest == addr);
	endfunction

	assign writeValid = hostWriteValid || writebackValid;
	assign writeSel = hostWriteValid ? hostWrite : writeback; // Host wins a collision
	assign writeLanes = writeSel.value;

	always_ff @(posedge Clock or posedge Reset)
	begin
		if (Reset)
		begin
			for (int c = 0; c < componentCount; c++)
			begin
				for (int r = 0; r < regCount; r++)
					laneMem[c][r] <= '0;
			end
		end
		else if (writeValid)
		begin
			for (int c = 0; c < componentCount; c++)
			begin
				if (writeSel.mask[c]) // Unmasked lanes keep their value
					laneMem[c][writeSel.dest] <= writeLanes[c];
			end
		end
	end

	// Write-first read ports
	always_ff @(posedge Clock or posedge Reset)
	begin
		if (Reset)
		begin
			readLanesA <= '0;
			readLanesB <= '0;
		end
		else
		begin
			for (int c = 0; c < componentCount; c++)
			begin
				readLanesA[c] <= writeHit(c, readAddrA) ? writeLanes[c] : laneMem[c][readAddrA];
				readLanesB[c] <= writeHit(c, readAddrB) ? writeLanes[c] : laneMem[c][readAddrB];
			end
		end
	end

	assign readDataA = readLanesA;
	assign readDataB = readLanesB;

endmodule

`default_nettype wire

// File: vectorExecute.sv
`timescale 1ns/1ps
`default_nettype none

module vectorExecute
	import vectorPkg::*;
	import isaPkg::*;
(
	input logic Clock,
	input logic Reset,
	input logic issueValid,
	input issueT issue,
	output logic writebackValid, // Also the core result strobe
	output regWriteT writeback
);

	lanesT laneA;
	lanesT laneB;
	lanesT sumLanes;
	lanesT diffLanes;
	lanesT prodLanes; // Truncated Q16.16 products
	componentT dotSum;
	vectorT resultValue;
	logic resultKnown; // Low for unused opcodes

	// Full signed product, then keep bits 47 to 16
	function automatic componentT fixedMul(input componentT a, input componentT b);
		logic signed [2*componentWidth-1:0] wideA;
		logic signed [2*componentWidth-1:0] wideB;
		logic signed [2*componentWidth-1:0] product;
		wideA = a; // Sign extended
		wideB = b;
		product = wideA * wideB;
		return product[fracBits +: componentWidth]; // Truncate toward minus infinity
	endfunction

	assign laneA = issue.operandA;
	assign laneB = issue.operandB;

	// All lane results are formed in parallel and picked below
	always_comb
	begin
		dotSum = '0;
		for (int c = 0; c < componentCount; c++)
		begin
			sumLanes[c] = laneA[c] + laneB[c]; // Wraps at 32 bits
			diffLanes[c] = laneA[c] - laneB[c];
			prodLanes[c] = fixedMul(laneA[c], laneB[c]);
			dotSum = dotSum + prodLanes[c];
		end
	end

	always_comb
	begin
		resultKnown = 1'b1;
		resultValue = issue.operandA;
		case (issue.opcode)
			Mov: resultValue = issue.operandA;
			Add: resultValue = sumLanes;
			Sub: resultValue = diffLanes;
			Mul: resultValue = prodLanes;
			Dot: resultValue = {dotSum, dotSum, dotSum}; // Broadcast to x, y, z
			default: resultKnown = 1'b0;
		endcase
	end

	always_ff @(posedge Clock or posedge Reset)
	begin
		if (Reset)
			writebackValid <= 1'b0;
		else
			writebackValid <= issueValid && resultKnown;
	end

	// Dest and mask travel unchanged with the result
	always_ff @(posedge Clock)
	begin
		if (issueValid)
		begin
			writeback.dest <= issue.dest;
			writeback.mask <= issue.mask;
			writeback.value <= resultValue;
		end
	end

endmodule

`default_nettype wire

// File: vectorCore.sv
`timescale 1ns/1ps
`default_nettype none

module vectorCore
	import vectorPkg::*;
	import isaPkg::*;
(
	input logic Clock,
	input logic Reset,
	input logic instValid,
	input instructionT instruction,
	input logic hostWriteValid, // Only while no instruction is in flight
	input regWriteT hostWrite,
	output logic resultValid, // Two cycles after instValid
	output regWriteT result
);

	regAddrT readAddrA;
	regAddrT readAddrB;
	vectorT readDataA;
	vectorT readDataB;
	logic issueValid;
	issueT issue;
	logic writebackValid;
	regWriteT writeback;

	// Stage 1 capture and bypass
	operandFetch i_operandFetch (
		.Clock(Clock),
		.Reset(Reset),
		.instValid(instValid),
		.instruction(instruction),
		.readDataA(readDataA),
		.readDataB(readDataB),
		.writebackValid(writebackValid),
		.writeback(writeback),
		.readAddrA(readAddrA),
		.readAddrB(readAddrB),
		.issueValid(issueValid),
		.issue(issue)
	);

	vectorRegFile i_vectorRegFile (
		.Clock(Clock),
		.Reset(Reset),
		.readAddrA(readAddrA),
		.readAddrB(readAddrB),
		.hostWriteValid(hostWriteValid),
		.hostWrite(hostWrite),
		.writebackValid(writebackValid),
		.writeback(writeback),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	// Stage 2 arithmetic
	vectorExecute i_vectorExecute (
		.Clock(Clock),
		.Reset(Reset),
		.issueValid(issueValid),
		.issue(issue),
		.writebackValid(writebackValid),
		.writeback(writeback)
	);

	assign resultValid = writebackValid; // Same strobe that writes the RAM
	assign result = writeback;

endmodule

`default_nettype wire

// File: vectorCoreTests.svh
`ifndef VECTOR_CORE_TESTS_SVH
`define VECTOR_CORE_TESTS_SVH

	// No strobe after reset and an unwritten register reads as zero
	task automatic resetTest();
		currentTest = "reset";
		idleCycles(4); // Checker flags any stray strobe
		issueInstruction(Mov, 5'd8, 5'd7, 5'd0, 3'b111);
		waitForResults();
	endtask

	task automatic preloadMovTest();
		vectorT value;
		currentTest = "preload and mov";
		for (int i = 0; i < 4; i++)
		begin
			value.x = (i + 1) << fracBits; // Whole numbers 1 to 4
			value.y = -((i + 1) << fracBits);
			value.z = nextRandom();
			hostWriteVector(5'(i + 1), 3'b111, value);
		end
		for (int i = 0; i < 4; i++)
			issueInstruction(Mov, 5'(i + 10), 5'(i + 1), 5'd0, 3'b111);
		waitForResults();
	endtask

	task automatic arithmeticTest();
		currentTest = "arithmetic";
		// Extremes so that ADD wraps in x and y and SUB wraps in z both ways
		hostWriteVector(5'd1, 3'b111, {32'h7FFF_FFFF, 32'h8000_0000, 32'h0001_8000});
		hostWriteVector(5'd2, 3'b111, {32'h0000_0001, 32'hFFFF_FFFF, 32'h8000_0000});
		issueInstruction(Add, 5'd3, 5'd1, 5'd2, 3'b111);
		issueInstruction(Sub, 5'd4, 5'd2, 5'd1, 3'b111);
		issueInstruction(Sub, 5'd5, 5'd1, 5'd2, 3'b111);
		waitForResults();
		// 1.5, -2.25 and 0.5 in Q16.16
		hostWriteVector(5'd5, 3'b111, {32'h0001_8000, 32'hFFFD_C000, 32'h0000_8000});
		hostWriteVector(5'd6, 3'b111, {32'hFFFD_C000, 32'h0000_8000, 32'h0001_8000});
		hostWriteVector(5'd9, 3'b111, {32'h0000_0001, 32'hFFFF_FFFF, 32'h0001_8000}); // LSB sized
		issueInstruction(Mul, 5'd7, 5'd5, 5'd6, 3'b111);
		issueInstruction(Dot, 5'd8, 5'd5, 5'd6, 3'b111);
		issueInstruction(Mul, 5'd10, 5'd9, 5'd5, 3'b111); // Fractional LSBs truncate
		issueInstruction(Dot, 5'd11, 5'd9, 5'd6, 3'b111);
		waitForResults();
	endtask

	task automatic writeMaskTest();
		currentTest = "write mask";
		hostWriteVector(5'd12, 3'b111, {32'h0001_0000, 32'h0002_0000, 32'h0003_0000});
		hostWriteVector(5'd12, 3'b010, {32'h0AAA_0000, 32'h0BBB_0000, 32'h0CCC_0000}); // y only
		hostWriteVector(5'd13, 3'b111, {32'h1111_1111, 32'h2222_2222, 32'h3333_3333});
		issueInstruction(Mov, 5'd13, 5'd12, 5'd0, 3'b101); // x and z
		issueInstruction(Mov, 5'd14, 5'd13, 5'd0, 3'b111); // Shows the merged r13
		issueInstruction(Add, 5'd12, 5'd12, 5'd13, 3'b001);
		issueInstruction(Mov, 5'd15, 5'd12, 5'd0, 3'b111);
		issueInstruction(Mov, 5'd16, 5'd12, 5'd0, 3'b000); // Strobe with an empty mask
		waitForResults();
	endtask

	/*
	 * Each step reads the previous destination.
	 * Gap 0 needs the bypass, gap 1 the write-first read, gap 2 plain RAM
	 */
	task automatic dependencyChainTest();
		opcodeT ops [4];
		maskT masks [3];
		regAddrT prev;
		regAddrT dest;
		int step;
		currentTest = "dependency chain";
		ops = '{Add, Mul, Sub, Dot};
		masks = '{3'b111, 3'b101, 3'b011}; // Partial masks mix old and new lanes
		hostWriteVector(5'd20, 3'b111, {32'h0001_0000, 32'h0002_0000, 32'h0003_0000});
		hostWriteVector(5'd21, 3'b111, {32'h0000_8000, 32'hFFFF_8000, 32'h0001_8000});
		prev = 5'd20;
		step = 0;
		for (int gap = 0; gap < 3; gap++)
		begin
			for (int k = 0; k < 4; k++)
			begin
				dest = (prev == 5'd20) ? 5'd23 : 5'd20;
				issueInstruction(ops[step % 4], dest, prev, 5'd21, masks[step % 3]);
				prev = dest;
				step++;
				if (gap > 0)
					idleCycles(gap);
			end
		end
		issueInstruction(Mov, 5'd22, prev, 5'd0, 3'b111);
		waitForResults();
	endtask

	task automatic randomStreamTest();
		logic [31:0] r;
		vectorT value;
		currentTest = "random stream";
		for (int i = 0; i < regCount; i++)
		begin
			value.x = nextRandom();
			value.y = nextRandom();
			value.z = nextRandom();
			hostWriteVector(5'(i), 3'b111, value);
		end
		for (int n = 0; n < 200; n++)
		begin
			r = nextRandom();
			issueInstruction(opcodeT'(r[2:0]), r[7:3], r[12:8], r[17:13], r[20:18]); // All 8 codes
		end
		waitForResults();
	endtask

`endif

// File: vectorCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module vectorCoreTb
	import vectorPkg::*;
	import isaPkg::*;
();

	localparam int clockPeriod = 8; // ns
	localparam int testInstructions = 230; // Strobes over all tests
	localparam int marginCycles = 400; // Host writes, drains and reset
	localparam int drainLimit = 8; // Cycles allowed for outstanding results

	typedef struct packed {
		int dueCycle; // Cycle in which resultValid must be high
		regWriteT write;
	} expectT;

	logic Clock;
	logic Reset;
	logic instValid;
	instructionT instruction;
	logic hostWriteValid;
	regWriteT hostWrite;
	logic resultValid;
	regWriteT result;

	vectorT model [regCount]; // Reference register contents
	expectT pending [$]; // Oldest first
	int cycle = 0;
	int errorCount = 0;
	int checkCount = 0;
	string currentTest = "reset";
	logic [31:0] rngState = 32'habb9_ddaf;

	vectorCore i_vectorCore (.*);

	always #(clockPeriod / 2) Clock = ~Clock;

	always @(posedge Clock)
		cycle <= cycle + 1;

	// Xorshift32 step
	function automatic logic [31:0] nextRandom();
		logic [31:0] s;
		s = rngState;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		rngState = s;
		return s;
	endfunction

	// Q16.16 product as bits 47 to 16 of the exact value
	function automatic int qMul(input int a, input int b);
		longint product;
		product = longint'(a) * longint'(b);
		return int'(product >>> fracBits); // Floor, then wrap to 32 bits
	endfunction

	function automatic vectorT expectedValue(input opcodeT op, input vectorT a, input vectorT b);
		lanesT la;
		lanesT lb;
		lanesT lr;
		int dot;
		la = a;
		lb = b;
		dot = 0;
		for (int c = 0; c < 3; c++)
		begin
			dot += qMul(la[c], lb[c]); // Wraps like the hardware sum
			case (op)
				Add: lr[c] = la[c] + lb[c];
				Sub: lr[c] = la[c] - lb[c];
				Mul: lr[c] = qMul(la[c], lb[c]);
				default: lr[c] = la[c]; // Mov
			endcase
		end
		return (op == Dot) ? {dot, dot, dot} : lr;
	endfunction

	// Lane c follows mask bit c, so bit 2 is x
	function automatic vectorT mergeMasked(input vectorT old, input vectorT value, input maskT mask);
		lanesT merged;
		lanesT fresh;
		merged = old;
		fresh = value;
		for (int c = 0; c < 3; c++)
			if (mask[c])
				merged[c] = fresh[c];
		return merged;
	endfunction

	task automatic compareResult(input string testName, input regWriteT expected,
		input regWriteT actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("mismatch %s: expected %h, actual %h", testName, expected, actual);
		end
	endtask

	task automatic reportFailure(input string what);
		errorCount++;
		$display("error in %s: %s", currentTest, what);
	endtask

	// Quiet cycles with inputs changed 1 ns after the edge
	task automatic idleCycles(input int count);
		repeat (count)
		begin
			@(posedge Clock);
			#1;
			instValid = 1'b0;
			hostWriteValid = 1'b0;
		end
	endtask

	task automatic hostWriteVector(input regAddrT dest, input maskT mask, input vectorT value);
		@(posedge Clock);
		#1;
		instValid = 1'b0;
		hostWriteValid = 1'b1;
		hostWrite.dest = dest;
		hostWrite.mask = mask;
		hostWrite.value = value;
		model[dest] = mergeMasked(model[dest], value, mask);
		idleCycles(1);
	endtask

	// One strobe with the model advanced in program order
	task automatic issueInstruction(input opcodeT op, input regAddrT dest,
		input regAddrT srcA, input regAddrT srcB, input maskT mask);
		expectT entry;
		@(posedge Clock);
		#1;
		hostWriteValid = 1'b0;
		instValid = 1'b1;
		instruction.opcode = op;
		instruction.dest = dest;
		instruction.srcA = srcA;
		instruction.srcB = srcB;
		instruction.mask = mask;
		if (op inside {Mov, Add, Sub, Mul, Dot}) // Other codes retire silently
		begin
			entry.dueCycle = cycle + 2;
			entry.write.dest = dest;
			entry.write.mask = mask;
			entry.write.value = expectedValue(op, model[srcA], model[srcB]);
			pending.push_back(entry);
			model[dest] = mergeMasked(model[dest], entry.write.value, mask);
		end
	endtask

	task automatic waitForResults();
		int waited;
		waited = 0;
		idleCycles(1);
		while (pending.size() != 0 && waited < drainLimit)
		begin
			@(posedge Clock);
			waited++;
		end
		if (pending.size() != 0)
		begin
			reportFailure($sformatf("%0d results never arrived", pending.size()));
			pending.delete();
		end
	endtask

	// Result checker sampled mid-cycle where outputs are settled
	always @(negedge Clock)
	begin
		if (resultValid !== 1'b0 && (pending.size() == 0 || pending[0].dueCycle != cycle))
			reportFailure($sformatf("unexpected resultValid in cycle %0d", cycle));
		else if (resultValid === 1'b1)
		begin
			compareResult(currentTest, pending[0].write, result);
			void'(pending.pop_front());
		end
		else if (pending.size() != 0 && pending[0].dueCycle == cycle)
		begin
			reportFailure($sformatf("resultValid missing in cycle %0d", cycle));
			void'(pending.pop_front());
		end
	end

	`include "vectorCoreTests.svh"

	initial
	begin
		Clock = 1'b0;
		Reset = 1'b1;
		instValid = 1'b0;
		instruction = '0;
		hostWriteValid = 1'b0;
		hostWrite = '0;
		for (int r = 0; r < regCount; r++)
			model[r] = '0; // Register file leaves reset cleared
		repeat (5) @(posedge Clock);
		#1;
		Reset = 1'b0;
		resetTest();
		preloadMovTest();
		arithmeticTest();
		writeMaskTest();
		dependencyChainTest();
		randomStreamTest();
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		#((testInstructions + marginCycles) * clockPeriod);
		$display("timeout in %s, checks: %0d, errors: %0d", currentTest, checkCount, errorCount);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: vectorCore.f
+incdir+.
vectorPkg.sv
isaPkg.sv
operandFetch.sv
vectorRegFile.sv
vectorExecute.sv
vectorCore.sv
vectorCoreTb.sv

// File: Makefile
TOP = vectorCoreTb
FILELIST = vectorCore.f

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module vectorCore -f $(FILELIST)
	verilator --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	verilator --binary --timing --top-module $(TOP) -f $(FILELIST) -o vectorCoreSim
	@out="$$(./obj_dir/vectorCoreSim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
